//--- src/mem_stage_settings.svh
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Data path and address width
`define MEM_DATA_WIDTH 32

// Destination register index
`define MEM_REG_ADDR_WIDTH 5

// Data RAM depth in words
`define MEM_DMEM_WORDS 256

// Slow memory model, extra cycles before the RAM is enabled
`define MEM_WAIT_CYCLES 2

`endif

//--- src/mem_stage_pkg.sv
`include "mem_stage_settings.svh"

package mem_stage_pkg;

    // Major opcodes, anything else is a non-memory instruction
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_WAIT    = 2'd1,
        ST_ACCESS  = 2'd2,
        ST_RESPOND = 2'd3
    } mem_state_e;

    typedef struct packed {
        logic      is_load;
        logic      is_store;
        mem_size_e size;
        logic      is_unsigned;  // LBU / LHU
        logic      fault;        // Misaligned or unknown funct3
    } mem_ctl_t;

    // From execute
    typedef struct packed {
        logic [`MEM_DATA_WIDTH-1:0]     pc;
        logic [`MEM_DATA_WIDTH-1:0]     inst;
        logic [`MEM_DATA_WIDTH-1:0]     result;
        logic [`MEM_DATA_WIDTH-1:0]     dmem_addr;
        logic [`MEM_DATA_WIDTH-1:0]     rs2_data;
        logic [`MEM_REG_ADDR_WIDTH-1:0] rd_addr;
    } ex_mem_t;

    // To writeback
    typedef struct packed {
        logic [`MEM_DATA_WIDTH-1:0]     pc;
        logic [`MEM_DATA_WIDTH-1:0]     inst;
        logic [`MEM_DATA_WIDTH-1:0]     wb_data;  // Load value or execute result
        logic [`MEM_REG_ADDR_WIDTH-1:0] rd_addr;
        logic                           fault;
    } mem_wb_t;

endpackage

//--- src/mem_access_decoder.sv
module mem_access_decoder import mem_stage_pkg::*; (
    input  logic [31:0] inst_i,
    input  logic [1:0]  addr_lo_i,
    output mem_ctl_t    ctl_o
);

    logic [2:0] funct3;
    logic       misaligned;

    assign funct3 = inst_i[14:12];

    always_comb begin
        ctl_o = '0;
        case (opcode_e'(inst_i[6:0]))
            OP_LOAD: begin
                ctl_o.is_load = 1'b1;
                case (funct3)
                    3'b000: ctl_o.size = SIZE_BYTE;  // LB
                    3'b001: ctl_o.size = SIZE_HALF;  // LH
                    3'b010: ctl_o.size = SIZE_WORD;  // LW
                    3'b100: begin                    // LBU
                        ctl_o.size        = SIZE_BYTE;
                        ctl_o.is_unsigned = 1'b1;
                    end
                    3'b101: begin                    // LHU
                        ctl_o.size        = SIZE_HALF;
                        ctl_o.is_unsigned = 1'b1;
                    end
                    default: ctl_o.fault = 1'b1;
                endcase
            end
            OP_STORE: begin
                ctl_o.is_store = 1'b1;
                case (funct3)
                    3'b000:  ctl_o.size = SIZE_BYTE;  // SB
                    3'b001:  ctl_o.size = SIZE_HALF;  // SH
                    3'b010:  ctl_o.size = SIZE_WORD;  // SW
                    default: ctl_o.fault = 1'b1;
                endcase
            end
            default: ;  // Pass-through instruction
        endcase

        // Natural alignment only
        misaligned = (ctl_o.size == SIZE_HALF && addr_lo_i[0]) ||
                     (ctl_o.size == SIZE_WORD && addr_lo_i != 2'b00);
        if ((ctl_o.is_load || ctl_o.is_store) && misaligned) begin
            ctl_o.fault = 1'b1;
        end
    end

endmodule

//--- src/load_align.sv
`include "mem_stage_settings.svh"

module load_align import mem_stage_pkg::*; (
    input  logic [`MEM_DATA_WIDTH-1:0] word_i,
    input  logic [1:0]                 addr_lo_i,
    input  mem_size_e                  size_i,
    input  logic                       unsigned_i,
    output logic [`MEM_DATA_WIDTH-1:0] data_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        sign_bit;

    // Byte lane picked by the two low address bits
    always_comb begin
        case (addr_lo_i)
            2'd0:    byte_sel = word_i[7:0];
            2'd1:    byte_sel = word_i[15:8];
            2'd2:    byte_sel = word_i[23:16];
            default: byte_sel = word_i[31:24];
        endcase
    end

    assign half_sel = addr_lo_i[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (size_i)
            SIZE_BYTE: begin
                sign_bit = byte_sel[7] & ~unsigned_i;
                data_o   = {{(`MEM_DATA_WIDTH-8){sign_bit}}, byte_sel};
            end
            SIZE_HALF: begin
                sign_bit = half_sel[15] & ~unsigned_i;
                data_o   = {{(`MEM_DATA_WIDTH-16){sign_bit}}, half_sel};
            end
            default: begin
                sign_bit = 1'b0;
                data_o   = word_i;  // Full word untouched
            end
        endcase
    end

endmodule

//--- src/store_mask_gen.sv
`include "mem_stage_settings.svh"

module store_mask_gen import mem_stage_pkg::*; (
    input  logic [1:0]                   size_i,
    input  logic [1:0]                   addr_lo_i,
    input  logic [`MEM_DATA_WIDTH-1:0]   wdata_i,
    output logic [`MEM_DATA_WIDTH/8-1:0] wmask_o,
    output logic [`MEM_DATA_WIDTH-1:0]   wdata_o
);

    mem_size_e size;

    assign size = mem_size_e'(size_i);

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                wdata_o = {4{wdata_i[7:0]}};      // Same byte on every lane
                wmask_o = 4'b0001 << addr_lo_i;
            end
            SIZE_HALF: begin
                wdata_o = {2{wdata_i[15:0]}};
                wmask_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            SIZE_WORD: begin
                wdata_o = wdata_i;
                wmask_o = 4'b1111;
            end
            default: begin
                // Encoding not produced by the decoder
                wdata_o = wdata_i;
                wmask_o = 4'b0000;
            end
        endcase
    end

endmodule

//--- src/dmem_ram.sv
`include "mem_stage_settings.svh"

module dmem_ram #(
    parameter int DEPTH = `MEM_DMEM_WORDS
) (
    input  logic                         clk,
    input  logic                         en_i,
    input  logic                         we_i,
    input  logic [$clog2(DEPTH)-1:0]     addr_i,
    input  logic [`MEM_DATA_WIDTH/8-1:0] wmask_i,
    input  logic [`MEM_DATA_WIDTH-1:0]   wdata_i,
    output logic [`MEM_DATA_WIDTH-1:0]   rdata_o
);

    localparam int LANES = `MEM_DATA_WIDTH / 8;

    logic [`MEM_DATA_WIDTH-1:0] mem_q [DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem_q[addr_i];  // Read-first, old word on a write
            if (we_i) begin
                for (int b = 0; b < LANES; b++) begin
                    if (wmask_i[b]) begin
                        mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    // Write strobe only comes with an enabled access
    a_we_needs_en: assert property (@(posedge clk) we_i |-> en_i)
        else $error("dmem_ram: write without enable");

endmodule

//--- src/wait_timer.sv
module wait_timer (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       load_i,
    input  logic [7:0] count_i,
    output logic       done_o
);

    logic [7:0] count_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= count_i;
        end else if (count_q != '0) begin
            count_q <= count_q - 8'd1;  // Holds at zero
        end
    end

    assign done_o = (count_q == '0);

    // Controller only reloads once the previous wait ran out
    a_no_early_load: assert property (
        @(posedge clk) disable iff (reset_i) load_i |-> count_q == '0
    ) else $error("wait_timer: reload while counting");

endmodule

//--- src/mem_ctrl_fsm.sv
module mem_ctrl_fsm import mem_stage_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     start_i,
    input  mem_ctl_t ctl_i,
    input  logic     timer_done_i,
    output logic     timer_load_o,
    output logic     ram_en_o,
    output logic     ram_we_o,
    output logic     capture_o,
    output logic     busy_o,
    output logic     wb_valid_o
);

    mem_state_e state_q;
    mem_state_e state_d;
    logic       is_mem;

    assign is_mem = ctl_i.is_load || ctl_i.is_store;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        timer_load_o = 1'b0;
        ram_en_o     = 1'b0;
        ram_we_o     = 1'b0;
        capture_o    = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (start_i && is_mem) begin
                    timer_load_o = 1'b1;
                    state_d      = ST_WAIT;
                end else if (start_i) begin
                    capture_o = 1'b1;  // Result goes straight out
                    state_d   = ST_RESPOND;
                end
            end
            ST_WAIT: begin
                // RAM request on the last wait cycle, word is back in ST_ACCESS
                if (timer_done_i) begin
                    ram_en_o = 1'b1;
                    ram_we_o = ctl_i.is_store && !ctl_i.fault;
                    state_d  = ST_ACCESS;
                end
            end
            ST_ACCESS: begin
                capture_o = 1'b1;
                state_d   = ST_RESPOND;
            end
            default: state_d = ST_IDLE;  // ST_RESPOND
        endcase
    end

    assign busy_o     = (state_q != ST_IDLE);
    assign wb_valid_o = (state_q == ST_RESPOND);

    // No back-pressure path, execute has to hold off while busy
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (reset_i) start_i |-> !busy_o
    ) else $error("mem_ctrl_fsm: strobe while busy");

endmodule

//--- src/mem_stage.sv
`include "mem_stage_settings.svh"

module mem_stage import mem_stage_pkg::*; #(
    parameter int WAIT_CYCLES = `MEM_WAIT_CYCLES
) (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    ex_valid_i,
    input  ex_mem_t ex_i,
    output logic    busy_o,
    output logic    wb_valid_o,
    output mem_wb_t wb_o
);

    localparam int RAM_AW = $clog2(`MEM_DMEM_WORDS);

    ex_mem_t                      ex_q;
    ex_mem_t                      ex_cur;
    mem_ctl_t                     ctl;
    logic                         timer_load;
    logic                         timer_done;
    logic                         ram_en;
    logic                         ram_we;
    logic                         capture;
    logic [`MEM_DATA_WIDTH/8-1:0] wmask;
    logic [`MEM_DATA_WIDTH-1:0]   wdata;
    logic [`MEM_DATA_WIDTH-1:0]   rdata;
    logic [`MEM_DATA_WIDTH-1:0]   load_data;
    mem_wb_t                      wb_d;
    mem_wb_t                      wb_q;

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            ex_q <= ex_i;  // Held for the whole memory access
        end
    end

    // Strobe cycle decodes the live input, later cycles the held copy
    assign ex_cur = ex_valid_i ? ex_i : ex_q;

    mem_access_decoder u_decoder (
        .inst_i   (ex_cur.inst),
        .addr_lo_i(ex_cur.dmem_addr[1:0]),
        .ctl_o    (ctl)
    );

    mem_ctrl_fsm u_ctrl (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (ex_valid_i),
        .ctl_i       (ctl),
        .timer_done_i(timer_done),
        .timer_load_o(timer_load),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .capture_o   (capture),
        .busy_o      (busy_o),
        .wb_valid_o  (wb_valid_o)
    );

    wait_timer u_timer (
        .clk    (clk),
        .reset_i(reset_i),
        .load_i (timer_load),
        .count_i(8'(WAIT_CYCLES)),
        .done_o (timer_done)
    );

    store_mask_gen u_mask (
        .size_i   (ctl.size),
        .addr_lo_i(ex_cur.dmem_addr[1:0]),
        .wdata_i  (ex_cur.rs2_data),
        .wmask_o  (wmask),
        .wdata_o  (wdata)
    );

    dmem_ram #(
        .DEPTH(`MEM_DMEM_WORDS)
    ) u_ram (
        .clk    (clk),
        .en_i   (ram_en),
        .we_i   (ram_we),
        .addr_i (ex_cur.dmem_addr[RAM_AW+1:2]),  // Word index
        .wmask_i(wmask),
        .wdata_i(wdata),
        .rdata_o(rdata)
    );

    load_align u_align (
        .word_i    (rdata),
        .addr_lo_i (ex_cur.dmem_addr[1:0]),
        .size_i    (ctl.size),
        .unsigned_i(ctl.is_unsigned),
        .data_o    (load_data)
    );

    always_comb begin
        wb_d.pc      = ex_cur.pc;
        wb_d.inst    = ex_cur.inst;
        wb_d.rd_addr = ex_cur.rd_addr;
        wb_d.fault   = ctl.fault;
        // Faulting load keeps the execute result
        wb_d.wb_data = (ctl.is_load && !ctl.fault) ? load_data : ex_cur.result;
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            wb_q <= wb_d;
        end
    end

    assign wb_o = wb_q;

endmodule

//--- tests/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

//--- tests/mem_stage_tb.sv
`include "mem_stage_settings.svh"

module mem_stage_tb import mem_stage_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT       = `MEM_WAIT_CYCLES;
    localparam int NUM_TESTS  = 34;
    localparam int MAX_CYCLES = NUM_TESTS * (WAIT + 6) + 50;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;

    typedef struct packed {
        logic [6:0]  op;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] data;   // Store data, or result for a non-memory op
        logic        rnd;    // Take data from the LFSR
        logic        fault;
    } test_t;

    localparam test_t TESTS [NUM_TESTS] = '{
        '{OPC_STORE, 3'd2, 32'h040, 32'h0, 1'b1, 1'b0},          // SW, LW back
        '{OPC_LOAD,  3'd2, 32'h040, 32'h0, 1'b0, 1'b0},
        '{OPC_STORE, 3'd2, 32'h044, 32'h80FF_7F01, 1'b0, 1'b0},  // Sign test pattern
        '{OPC_LOAD,  3'd0, 32'h046, 32'h0, 1'b0, 1'b0},          // LB of 0xFF
        '{OPC_LOAD,  3'd4, 32'h045, 32'h0, 1'b0, 1'b0},
        '{OPC_LOAD,  3'd0, 32'h045, 32'h0, 1'b0, 1'b0},          // LB of 0x7F
        '{OPC_LOAD,  3'd4, 32'h047, 32'h0, 1'b0, 1'b0},
        '{OPC_LOAD,  3'd1, 32'h046, 32'h0, 1'b0, 1'b0},          // LH of 0x80FF
        '{OPC_LOAD,  3'd5, 32'h046, 32'h0, 1'b0, 1'b0},
        '{OPC_LOAD,  3'd1, 32'h044, 32'h0, 1'b0, 1'b0},          // LH of 0x7F01
        '{OPC_LOAD,  3'd5, 32'h044, 32'h0, 1'b0, 1'b0},
        '{OPC_STORE, 3'd2, 32'h048, 32'h0, 1'b1, 1'b0},
        '{OPC_STORE, 3'd0, 32'h048, 32'h0, 1'b1, 1'b0},          // SB on every lane
        '{OPC_LOAD,  3'd2, 32'h048, 32'h0, 1'b0, 1'b0},          // Read back after each SB
        '{OPC_STORE, 3'd0, 32'h049, 32'h0, 1'b1, 1'b0},
        '{OPC_LOAD,  3'd2, 32'h048, 32'h0, 1'b0, 1'b0},
        '{OPC_STORE, 3'd0, 32'h04A, 32'h0, 1'b1, 1'b0},
        '{OPC_LOAD,  3'd2, 32'h048, 32'h0, 1'b0, 1'b0},
        '{OPC_STORE, 3'd0, 32'h04B, 32'h0, 1'b1, 1'b0},
        '{OPC_LOAD,  3'd2, 32'h048, 32'h0, 1'b0, 1'b0},
        '{OPC_STORE, 3'd2, 32'h04C, 32'h0, 1'b1, 1'b0},
        '{OPC_STORE, 3'd1, 32'h04C, 32'h0, 1'b1, 1'b0},          // SH low and high half
        '{OPC_LOAD,  3'd2, 32'h04C, 32'h0, 1'b0, 1'b0},
        '{OPC_STORE, 3'd1, 32'h04E, 32'h0, 1'b1, 1'b0},
        '{OPC_LOAD,  3'd2, 32'h04C, 32'h0, 1'b0, 1'b0},
        '{OPC_OPIMM, 3'd0, 32'h040, 32'h1234_5678, 1'b0, 1'b0},  // Pass-through
        '{OPC_LOAD,  3'd2, 32'h040, 32'h0, 1'b0, 1'b0},
        '{OPC_LOAD,  3'd1, 32'h041, 32'h0, 1'b0, 1'b1},          // Misaligned LH
        '{OPC_LOAD,  3'd2, 32'h042, 32'h0, 1'b0, 1'b1},
        '{OPC_STORE, 3'd1, 32'h045, 32'h0, 1'b1, 1'b1},          // Misaligned SH
        '{OPC_STORE, 3'd2, 32'h046, 32'h0, 1'b1, 1'b1},
        '{OPC_STORE, 3'd3, 32'h048, 32'h0, 1'b1, 1'b1},          // Unknown store funct3
        '{OPC_LOAD,  3'd2, 32'h044, 32'h0, 1'b0, 1'b0},
        '{OPC_LOAD,  3'd2, 32'h048, 32'h0, 1'b0, 1'b0}
    };

    logic        clk;
    logic        reset_i;
    logic        ex_valid_i;
    ex_mem_t     ex_i;
    logic        busy_o;
    logic        wb_valid_o;
    mem_wb_t     wb_o;
    logic [7:0]  ref_mem [1024];  // Byte view of the data RAM
    logic [31:0] lfsr_q;
    int          cycles = 0;
    int          errors;
    int          failed;
    int          cur_test;

    tb_clock_gen #(.PERIOD_NS(4)) u_clk_gen (.clk_o(clk));

    mem_stage #(
        .WAIT_CYCLES(WAIT)
    ) mem_stage_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .ex_valid_i(ex_valid_i),
        .ex_i      (ex_i),
        .busy_o    (busy_o),
        .wb_valid_o(wb_valid_o),
        .wb_o      (wb_o)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w      = {w[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Little-endian load rules of RV32I
    function automatic logic [31:0] expect_load(input logic [2:0] f3, input logic [9:0] a);
        logic [7:0]  b0;
        logic [15:0] h;
        b0 = ref_mem[a];
        h  = {ref_mem[a + 10'd1], b0};
        case (f3)
            3'd0:    return {{24{b0[7]}}, b0};
            3'd1:    return {{16{h[15]}}, h};
            3'd4:    return {24'd0, b0};
            3'd5:    return {16'd0, h};
            default: return {ref_mem[a + 10'd3], ref_mem[a + 10'd2], h};
        endcase
    endfunction

    task automatic ref_store(input logic [2:0] f3, input logic [9:0] a, input logic [31:0] d);
        int n;
        n = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a + 10'(i)] = d[i*8 +: 8];
        end
    endtask

    task automatic flag_error(input string msg);
        $display("[ERROR] %t: test %0d, %s", $time, cur_test, msg);
        errors++;
    endtask

    // Starts and ends on a falling edge
    task automatic run_test(input int idx);
        test_t       t;
        ex_mem_t     ex;
        logic [31:0] exp_data;
        logic        is_mem;
        int          exp_lat;
        int          lat;
        int          errs_before;

        cur_test    = idx;
        errs_before = errors;
        t           = TESTS[idx];
        is_mem      = (t.op == OPC_LOAD) || (t.op == OPC_STORE);
        if (t.rnd) begin
            random_word(t.data);
        end
        ex.pc        = 32'h0000_1000 + 32'(idx * 4);
        ex.inst      = {7'd0, 5'd2, 5'd1, t.funct3, 5'(idx + 1), t.op};
        ex.result    = is_mem ? t.addr : t.data;  // Address from the ALU
        ex.dmem_addr = t.addr;
        ex.rs2_data  = t.data;
        ex.rd_addr   = 5'(idx + 1);
        exp_data = (t.op == OPC_LOAD && !t.fault) ? expect_load(t.funct3, t.addr[9:0])
                                                  : ex.result;
        exp_lat  = is_mem ? WAIT + 3 : 1;

        if (busy_o !== 1'b0 || wb_valid_o !== 1'b0) begin
            flag_error($sformatf("busy_o %b wb_valid_o %b before strobe", busy_o, wb_valid_o));
        end
        ex_i       = ex;
        ex_valid_i = 1'b1;
        @(negedge clk);
        ex_valid_i = 1'b0;
        lat        = 1;
        while (wb_valid_o !== 1'b1 && lat <= exp_lat + 4) begin
            if (busy_o !== 1'b1) begin
                flag_error($sformatf("busy_o low %0d cycles after strobe", lat));
            end
            @(negedge clk);
            lat++;
        end

        if (wb_valid_o !== 1'b1) begin
            $display("Test %0d got no wb_valid_o within %0d cycles", idx, exp_lat + 4);
            errors++;
        end else begin
            if (busy_o !== 1'b1) begin
                flag_error("busy_o low in the wb_valid_o cycle");
            end
            if (lat != exp_lat) begin
                flag_error($sformatf("latency %0d, expected %0d", lat, exp_lat));
            end
            if (wb_o.wb_data !== exp_data) begin
                flag_error($sformatf("wb_data %h, expected %h", wb_o.wb_data, exp_data));
            end
            if (wb_o.fault !== t.fault) begin
                flag_error($sformatf("fault %b, expected %b", wb_o.fault, t.fault));
            end
            if (wb_o.pc !== ex.pc || wb_o.inst !== ex.inst || wb_o.rd_addr !== ex.rd_addr) begin
                flag_error($sformatf("pc/inst/rd %h/%h/%0d, expected %h/%h/%0d", wb_o.pc,
                                     wb_o.inst, wb_o.rd_addr, ex.pc, ex.inst, ex.rd_addr));
            end
        end

        if (t.op == OPC_STORE && !t.fault) begin
            ref_store(t.funct3, t.addr[9:0], t.data);
        end
        if (errors != errs_before) begin
            failed++;
        end
        $display("Test %0d %s: op %b funct3 %0d addr %h latency %0d", idx,
                 (errors == errs_before) ? "ok" : "bad", t.op, t.funct3, t.addr, lat);
        @(negedge clk);
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 10);
        reset_i    = 1'b1;
        ex_valid_i = 1'b0;
        ex_i       = '0;
        lfsr_q     = 32'h1be6;
        errors     = 0;
        failed     = 0;
        cur_test   = 0;
        repeat (2) @(negedge clk);
        reset_i = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, NUM_TESTS - failed, failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+src
src/mem_stage_pkg.sv
src/mem_access_decoder.sv
src/load_align.sv
src/store_mask_gen.sv
src/dmem_ram.sv
src/wait_timer.sv
src/mem_ctrl_fsm.sv
src/mem_stage.sv
tests/tb_clock_gen.sv
tests/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module mem_stage_tb -o mem_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0
